/* tiny_rv.f */
+incdir+verilog
verilog/rv32_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/hazard_if.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_hazard_unit.sv
verilog/rv_execute.sv
verilog/tiny_rv_core.sv
sim/tb_tiny_rv_core.sv

/* Makefile */
# Verilator build and run of the tiny RV32 core testbench

VERILATOR ?= verilator
TOP       ?= tb_tiny_rv_core
FILELIST  ?= tiny_rv.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "ALL TESTS PASSED" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_tiny_rv_core.sv */
// --------------------------------------------------
// testbench for the core with an instruction memory
// model, an in-order golden model and assertions
// --------------------------------------------------
`timescale 1ns/1ps
`include "core_params.svh"

module tb_tiny_rv_core;

    localparam int AW = $clog2(`IMEM_DEPTH);

    logic             clk = 1'b0;
    logic             rst_n;
    logic [`XLEN-1:0] instr_addr;
    logic             instr_req;
    logic             instr_gnt = 1'b0;
    logic [31:0]      instr_data = 32'h0;
    logic             wb_valid;
    logic [4:0]       wb_rd;
    logic [`XLEN-1:0] wb_data;

    logic [31:0] mem [0:`IMEM_DEPTH-1];
    logic [31:0] prog [$];
    logic [4:0]  exp_rd_q [$];
    logic [31:0] exp_data_q [$];
    logic [31:0] last_wb_data;
    logic [`XLEN-1:0] fetch_pc;
    int          exp_idx;
    integer      seed = 3464;
    bit          stall_en;
    bit          lat_s1;
    bit          lat_s2;
    bit          req_armed;
    int          cycles = 0;
    int          cycle_limit = 100;
    int          checks = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          final_errors = 0;

    tiny_rv_core dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_addr (instr_addr),
        .instr_req  (instr_req),
        .instr_gnt  (instr_gnt),
        .instr_data (instr_data),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // --------------------------------------------------
    // encoders and reference decode
    // --------------------------------------------------
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [2:0] f3);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input int imm);
        logic [31:0] v;
        v = imm;
        return {v[11:0], rs1, 3'b000, rd, 7'b0010011};
    endfunction

    // true for ADD, SUB, XOR and ADDI
    function automatic bit word_retires(input logic [31:0] w);
        bit r_ok;
        r_ok = (w[6:0] == 7'b0110011) &&
               ((w[14:12] == 3'b000 && (w[31:25] == 7'b0000000 || w[31:25] == 7'b0100000)) ||
                (w[14:12] == 3'b100 && w[31:25] == 7'b0000000));
        return r_ok || (w[6:0] == 7'b0010011 && w[14:12] == 3'b000);
    endfunction

    // in-order execution with one expected writeback per retiring word
    task automatic predict_writebacks();
        logic [31:0] gregs [0:31];
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        for (int i = 0; i < 32; i++) begin
            gregs[i] = 32'h0;
        end
        exp_rd_q.delete();
        exp_data_q.delete();
        foreach (prog[k]) begin
            w = prog[k];
            if (word_retires(w)) begin
                a = gregs[w[19:15]];
                b = gregs[w[24:20]];
                if (w[6:0] == 7'b0010011) begin
                    res = a + {{20{w[31]}}, w[31:20]};
                end else if (w[14:12] == 3'b100) begin
                    res = a ^ b;
                end else if (w[30]) begin
                    res = a - b;
                end else begin
                    res = a + b;
                end
                exp_rd_q.push_back(w[11:7]);
                exp_data_q.push_back(res);
                if (w[11:7] != 5'd0) begin
                    gregs[w[11:7]] = res;
                end
            end
        end
    endtask

    // load prog, reset the core and wait for every expected writeback
    task automatic run_program(input bit stall);
        rst_n = 1'b0;
        for (int i = 0; i < `IMEM_DEPTH; i++) begin
            mem[AW'(i)] = {i[24:0], 7'b1111111};
        end
        foreach (prog[k]) begin
            mem[AW'(k)] = prog[k];
        end
        predict_writebacks();
        stall_en = stall;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        while (exp_idx < exp_rd_q.size()) @(negedge clk);
        repeat (4) @(negedge clk);
    endtask

    // --------------------------------------------------
    // memory model with grant masked by random stalls
    // --------------------------------------------------
    always @(negedge clk) begin
        instr_gnt  <= instr_req && !(stall_en && (($random(seed) & 32'd3) == 32'd0));
        instr_data <= mem[instr_addr[AW+1:2]];
    end

    // fetch port, writeback values and the fixed two-cycle latency
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_idx   = 0;
            lat_s1    = 1'b0;
            lat_s2    = 1'b0;
            fetch_pc  = `RESET_PC;
            req_armed = 1'b0;
        end else begin
            // request rises in the first cycle after reset and then stays up
            assert (instr_req == req_armed) else begin
                $display("ERROR at %0t: instr_req is %0b, expected %0b", $time, instr_req,
                         req_armed);
                value_errors++;
            end
            req_armed = 1'b1;
            if (instr_req && instr_gnt) begin
                assert (instr_addr == fetch_pc) else begin
                    $display("ERROR at %0t: fetch from %h, expected %h", $time, instr_addr,
                             fetch_pc);
                    value_errors++;
                end
                fetch_pc = fetch_pc + 32'd4;
            end
            assert (wb_valid == lat_s2) else begin
                $display("ERROR at %0t: wb_valid is %0b, expected %0b", $time, wb_valid, lat_s2);
                value_errors++;
            end
            lat_s2 = lat_s1;
            lat_s1 = instr_req && instr_gnt && word_retires(instr_data);
            if (wb_valid) begin
                assert (exp_idx < exp_rd_q.size()) else begin
                    $display("a writeback to x%0d at %0t came with nothing left to expect",
                             wb_rd, $time);
                    other_errors++;
                end
                if (exp_idx < exp_rd_q.size()) begin
                    assert (wb_rd == exp_rd_q[exp_idx]) else begin
                        $display("ERROR at %0t: wb_rd x%0d, expected x%0d", $time, wb_rd,
                                 exp_rd_q[exp_idx]);
                        value_errors++;
                    end
                    assert (wb_data == exp_data_q[exp_idx]) else begin
                        $display("ERROR at %0t: wb_data %h, expected %h", $time, wb_data,
                                 exp_data_q[exp_idx]);
                        value_errors++;
                    end
                    checks++;
                    exp_idx++;
                end
                last_wb_data = wb_data;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: the programs did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // --------------------------------------------------
    // programs
    // --------------------------------------------------
    initial begin
        int n_double;
        int n_fib;
        int total;
        rst_n    = 1'b0;
        stall_en = 1'b0;
        n_double = 1 + ($unsigned($random(seed)) % 31);
        n_fib    = 1 + ($unsigned($random(seed)) % 10);
        total    = (1 + n_double) + 2 * (2 + 3 * n_fib) + 9 + 5;
        cycle_limit = 8 * total + 100;

        // doubler where every add depends on the one before
        prog.delete();
        prog.push_back(addi_word(5'd1, 5'd0, 1));
        for (int i = 0; i < n_double; i++) begin
            prog.push_back(r_type(7'b0000000, 5'd1, 5'd1, 5'd1, 3'b000));
        end
        run_program(1'b0);
        assert (last_wb_data == (32'h1 << n_double)) else begin
            $display("ERROR at %0t: doubler ended at %h after %0d adds", $time, last_wb_data,
                     n_double);
            final_errors++;
        end

        // fibonacci rotation forwarding into operand a and b
        prog.delete();
        prog.push_back(addi_word(5'd1, 5'd0, 1));
        prog.push_back(addi_word(5'd2, 5'd0, 1));
        for (int i = 0; i < n_fib; i++) begin
            prog.push_back(r_type(7'b0000000, 5'd3, 5'd1, 5'd2, 3'b000));
            prog.push_back(r_type(7'b0000000, 5'd1, 5'd3, 5'd2, 3'b000));
            prog.push_back(r_type(7'b0000000, 5'd2, 5'd1, 5'd3, 3'b000));
        end
        run_program(1'b0);
        run_program(1'b1);

        // sub, xor, negative immediates and x0
        prog.delete();
        prog.push_back(addi_word(5'd5, 5'd0, -7));
        prog.push_back(addi_word(5'd6, 5'd0, -300));
        prog.push_back(r_type(7'b0100000, 5'd7, 5'd5, 5'd6, 3'b000));
        prog.push_back(r_type(7'b0000000, 5'd8, 5'd7, 5'd5, 3'b100));
        prog.push_back(addi_word(5'd0, 5'd8, 123));
        prog.push_back(r_type(7'b0000000, 5'd9, 5'd0, 5'd0, 3'b000));
        prog.push_back(r_type(7'b0100000, 5'd10, 5'd9, 5'd8, 3'b000));
        prog.push_back(r_type(7'b0000000, 5'd11, 5'd10, 5'd6, 3'b100));
        prog.push_back(addi_word(5'd12, 5'd11, -2048));
        run_program(1'b0);

        // unsupported words aimed at the registers that follow
        prog.delete();
        prog.push_back(addi_word(5'd2, 5'd0, 100));
        prog.push_back(r_type(7'b0000001, 5'd2, 5'd2, 5'd2, 3'b000));
        prog.push_back(r_type(7'b0000000, 5'd3, 5'd2, 5'd2, 3'b000));
        prog.push_back({12'h000, 5'd3, 3'b000, 5'd3, 7'b1111111});
        prog.push_back(addi_word(5'd4, 5'd3, -1));
        run_program(1'b0);

        $display("writebacks checked %0d, value errors %0d, unexpected writebacks %0d, %0s %0d",
                 checks, value_errors, other_errors, "final value errors", final_errors);
        if (value_errors == 0 && other_errors == 0 && final_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog/tiny_rv_core.sv */
// --------------------------------------------------
// three-stage RV32 core top, instruction port in and
// writeback trace out
// --------------------------------------------------
`timescale 1ns/1ps
`include "core_params.svh"

module tiny_rv_core
    import rv32_isa_pkg::*, pipe_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    output logic [`XLEN-1:0] instr_addr,
    output logic             instr_req,
    input  logic             instr_gnt,
    input  logic [31:0]      instr_data,
    output logic             wb_valid,
    output reg_idx_t         wb_rd,
    output logic [`XLEN-1:0] wb_data
);

    logic   if_valid;
    if_id_t if_rec;
    logic   id_valid;
    id_ex_t id_rec;
    logic   wb_we;

    hazard_if hz0 ();

    // --------------------------------------------------
    // pipeline stages
    // --------------------------------------------------
    rv_fetch fetch0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr_addr (instr_addr),
        .instr_req  (instr_req),
        .instr_gnt  (instr_gnt),
        .instr_data (instr_data),
        .if_valid   (if_valid),
        .if_rec     (if_rec)
    );

    rv_decode decode0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_valid (if_valid),
        .if_rec   (if_rec),
        .hz       (hz0.decode),
        .wb_we    (wb_we),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .id_valid (id_valid),
        .id_rec   (id_rec)
    );

    rv_hazard_unit hazard0 (
        .hz (hz0.hazard)
    );

    rv_execute execute0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_valid (id_valid),
        .id_rec   (id_rec),
        .hz       (hz0.execute),
        .wb_valid (wb_valid),
        .wb_we    (wb_we),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

endmodule

/* verilog/rv_execute.sv */
// --------------------------------------------------
// execute stage: decode-to-execute register, ALU
// and the writeback drive back to decode
// --------------------------------------------------
`timescale 1ns/1ps
`include "core_params.svh"

module rv_execute
    import rv32_isa_pkg::*, pipe_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             id_valid,
    input  id_ex_t           id_rec,
    hazard_if.execute        hz,
    output logic             wb_valid,
    output logic             wb_we,
    output reg_idx_t         wb_rd,
    output logic [`XLEN-1:0] wb_data
);

    id_ex_t           ex_rec;
    logic             ex_valid;
    logic             ex_we;
    logic [`XLEN-1:0] alu_res;

    // unsupported words drop out here as bubbles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= id_valid & id_rec.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_valid) begin
            ex_rec <= id_rec;
        end
    end

    always_comb begin
        case (ex_rec.alu_op)
            ALU_SUB: alu_res = ex_rec.opa - ex_rec.opb;
            ALU_XOR: alu_res = ex_rec.opa ^ ex_rec.opb;
            default: alu_res = ex_rec.opa + ex_rec.opb;
        endcase
    end

    assign ex_we = ex_valid & ex_rec.we;

    assign wb_valid = ex_valid;
    assign wb_we    = ex_we && (ex_rec.rd != '0);
    assign wb_rd    = ex_rec.rd;
    assign wb_data  = alu_res;

    // destination seen by the hazard unit
    assign hz.ex_rd = ex_rec.rd;
    assign hz.ex_we = ex_we;

endmodule

/* verilog/rv_hazard_unit.sv */
// --------------------------------------------------
// read-after-write check against the instruction in
// execute, picks forwarding for each operand
// --------------------------------------------------
`timescale 1ns/1ps

module rv_hazard_unit
    import pipe_pkg::*;
(
    hazard_if.hazard hz
);

    logic ex_live;
    logic hit_a;
    logic hit_b;

    // execute is writing a real register
    assign ex_live = hz.ex_we && (hz.ex_rd != '0);

    assign hit_a = ex_live && hz.rs1_used && (hz.rs1 == hz.ex_rd);
    assign hit_b = ex_live && hz.rs2_used && (hz.rs2 == hz.ex_rd);

    // no stall path, the execute result is always ready
    assign hz.fwd_a = hit_a ? FWD_EX : FWD_RF;
    assign hz.fwd_b = hit_b ? FWD_EX : FWD_RF;

endmodule

/* verilog/rv_decode.sv */
// --------------------------------------------------
// decode stage: instruction decode, register file
// and operand forwarding from execute
// --------------------------------------------------
`timescale 1ns/1ps
`include "core_params.svh"

module rv_decode
    import rv32_isa_pkg::*, pipe_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             if_valid,
    input  if_id_t           if_rec,
    hazard_if.decode         hz,
    input  logic             wb_we,
    input  reg_idx_t         wb_rd,
    input  logic [`XLEN-1:0] wb_data,
    output logic             id_valid,
    output id_ex_t           id_rec
);

    logic [`XLEN-1:0] regs [1:31];
    logic [31:0]      instr;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    reg_idx_t         rs1;
    reg_idx_t         rs2;
    reg_idx_t         rd;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] rf_a;
    logic [`XLEN-1:0] rf_b;
    logic             is_op;
    logic             is_addi;
    logic             supported;
    alu_op_e          alu_op;

    // --------------------------------------------------
    // field extraction
    // --------------------------------------------------
    assign instr  = if_rec.instr;
    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];
    assign imm_i  = {{(`XLEN-12){instr[31]}}, instr[31:20]};

    always_comb begin
        is_op   = 1'b0;
        is_addi = 1'b0;
        alu_op  = ALU_ADD;
        if (opcode == OPC_OP) begin
            if (funct3 == F3_ADD_SUB && funct7 == F7_BASE) begin
                is_op = 1'b1;
            end else if (funct3 == F3_ADD_SUB && funct7 == F7_SUB) begin
                is_op  = 1'b1;
                alu_op = ALU_SUB;
            end else if (funct3 == F3_XOR && funct7 == F7_BASE) begin
                is_op  = 1'b1;
                alu_op = ALU_XOR;
            end
        end else if (opcode == OPC_OP_IMM && funct3 == F3_ADD_SUB) begin
            is_addi = 1'b1;
        end
    end

    assign supported = is_op | is_addi;

    // sources reported to the hazard unit
    assign hz.rs1      = rs1;
    assign hz.rs2      = rs2;
    assign hz.rs1_used = if_valid & supported;
    assign hz.rs2_used = if_valid & is_op;

    // --------------------------------------------------
    // register file, x0 is hardwired
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rf_a = (rs1 == '0) ? '0 : regs[rs1];
    assign rf_b = (rs2 == '0) ? '0 : regs[rs2];

    // operand select, the immediate wins for ADDI
    always_comb begin
        id_rec.valid  = supported;
        id_rec.rd     = rd;
        id_rec.we     = supported;
        id_rec.alu_op = alu_op;
        id_rec.opa    = (hz.fwd_a == FWD_EX) ? wb_data : rf_a;
        if (is_addi) begin
            id_rec.opb = imm_i;
        end else begin
            id_rec.opb = (hz.fwd_b == FWD_EX) ? wb_data : rf_b;
        end
    end

    assign id_valid = if_valid;

endmodule

/* verilog/rv_fetch.sv */
// --------------------------------------------------
// fetch stage: program counter, request/grant port
// and the fetch-to-decode register
// --------------------------------------------------
`timescale 1ns/1ps
`include "core_params.svh"

module rv_fetch
    import pipe_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    output logic [`XLEN-1:0] instr_addr,
    output logic             instr_req,
    input  logic             instr_gnt,
    input  logic [31:0]      instr_data,
    output logic             if_valid,
    output if_id_t           if_rec
);

    localparam logic [`XLEN-1:0] PC_STEP = `XLEN'(4);

    logic [`XLEN-1:0] pc;
    logic             req_q;
    logic             fire;

    // a fetch completes when request and grant meet
    assign fire = req_q & instr_gnt;

    // address stays put until granted
    assign instr_addr = pc;
    assign instr_req  = req_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= `RESET_PC;
            req_q    <= 1'b0;
            if_valid <= 1'b0;
        end else begin
            req_q    <= 1'b1;
            if_valid <= fire;
            if (fire) begin
                pc <= pc + PC_STEP;
            end
        end
    end

    // granted word together with its address
    always_ff @(posedge clk) begin
        if (fire) begin
            if_rec.pc    <= pc;
            if_rec.instr <= instr_data;
        end
    end

endmodule

/* verilog/hazard_if.sv */
// --------------------------------------------------
// source indices, execute destination and forward
// selects shared by decode, execute and hazard unit
// --------------------------------------------------
`timescale 1ns/1ps

interface hazard_if
    import rv32_isa_pkg::*, pipe_pkg::*;
    ;

    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     rs1_used;
    logic     rs2_used;
    reg_idx_t ex_rd;
    logic     ex_we;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    modport decode (output rs1, rs2, rs1_used, rs2_used, input fwd_a, fwd_b);
    modport execute (output ex_rd, ex_we);
    modport hazard (input rs1, rs2, rs1_used, rs2_used, ex_rd, ex_we, output fwd_a, fwd_b);

endinterface

/* verilog/pipe_pkg.sv */
// --------------------------------------------------
// records passed between pipeline stages and the
// forwarding select used by decode
// --------------------------------------------------
`include "core_params.svh"

package pipe_pkg;

    import rv32_isa_pkg::*;

    // fetch to decode
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      instr;
    } if_id_t;

    // decode to execute, operands already resolved
    typedef struct packed {
        logic             valid;
        reg_idx_t         rd;
        logic             we;
        alu_op_e          alu_op;
        logic [`XLEN-1:0] opa;
        logic [`XLEN-1:0] opb;
    } id_ex_t;

    // where an operand comes from
    typedef enum logic {
        FWD_RF = 1'b0,
        FWD_EX = 1'b1
    } fwd_sel_e;

endpackage

/* verilog/rv32_isa_pkg.sv */
// --------------------------------------------------
// RV32 encoding fields and ALU operations for the
// four supported instructions ADD, SUB, XOR, ADDI
// --------------------------------------------------
package rv32_isa_pkg;

    // architectural register number
    typedef logic [4:0] reg_idx_t;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011
    } opcode_e;

    // funct3, instr[14:12]
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_XOR     = 3'b100;

    // funct7, instr[31:25]
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_SUB  = 7'b0100000;

    // ALU operation carried to execute
    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_XOR = 2'd2
    } alu_op_e;

endpackage

/* verilog/core_params.svh */
// --------------------------------------------------
// core-wide sizes and the reset fetch address
// include wherever these widths are needed
// --------------------------------------------------
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// data and address width
`define XLEN 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// words in the instruction memory model
`define IMEM_DEPTH 1024

`endif
